// File: Bender.yml
package:
  name: io_system

sources:
  - hdl/io_pkg.sv
  - hdl/io_reg_file.sv
  - hdl/input_debounce.sv
  - hdl/seven_seg_scan.sv
  - hdl/ms_timer.sv
  - hdl/io_system.sv
  - target: test
    files:
      - bench/tb_io_system.sv

// File: bench/tb_io_system.sv
`timescale 1ns/1ps

module tb_io_system;

    localparam int CLK_PERIOD  = 4;
    // Rough cycle budget of all tests with a 4x margin on top
    localparam int TEST_CYCLES = 1250;
    localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 4;
    localparam int SCAN_CYCLES = io_pkg::NUM_DIGITS * (1 << io_pkg::SCAN_DIV_BITS);

    logic                      clk;
    logic                      rst;
    io_pkg::io_req_t           req;
    logic [31:0]               rdata;
    logic                      valid;
    logic [io_pkg::NUM_SW-1:0] sw;
    io_pkg::btn_t              btn;
    logic [15:0]               led;
    io_pkg::seg_drive_t        disp;

    int errors = 0;

    // Control word as the display should see it
    io_pkg::seg_ctrl_t exp_ctrl = io_pkg::seg_ctrl_t'(io_pkg::SEG_CTRL_RESET);

    io_system dut (
        .clk     (clk),
        .rst     (rst),
        .req_i   (req),
        .rdata_o (rdata),
        .valid_o (valid),
        .sw_i    (sw),
        .btn_i   (btn),
        .led_o   (led),
        .disp_o  (disp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] io_addr(input logic [7:0] offset);
        return {io_pkg::IO_START_ADDR[31:8], offset};
    endfunction

    // Segments gfedcba lit high here and inverted on return
    function automatic logic [6:0] hex_font(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // Index of the anode driven low
    function automatic int lit_digit(input logic [io_pkg::NUM_DIGITS-1:0] an);
        int idx;
        idx = 0;
        for (int k = 0; k < io_pkg::NUM_DIGITS; k++) begin
            if (!an[k]) idx = k;
        end
        return idx;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Accepts a difference of one either way modulo 2^32
    task automatic check_near(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        logic [31:0] diff;
        diff = act - exp;
        assert (diff == 32'd0 || diff == 32'd1 || diff == 32'hFFFF_FFFF) else begin
            errors++;
            $display("[FAIL] %s expected %h (+/-1) actual %h", name, exp, act);
        end
    endtask

    // Callers sit just after a falling edge
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        req.addr  = addr;
        req.wdata = data;
        req.wr    = 1'b1;
        req.rd    = 1'b0;
        @(negedge clk);
        req.wr = 1'b0;
    endtask

    // Data and valid land one clock after the address
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic vld);
        req.addr = addr;
        req.wr   = 1'b0;
        req.rd   = 1'b1;
        @(negedge clk);
        data   = rdata;
        vld    = valid;
        req.rd = 1'b0;
    endtask

    // Every lit digit checked over one full scan plus margin
    task automatic observe_scan(input logic [15:0] data);
        logic [io_pkg::NUM_DIGITS-1:0] seen;
        int k;
        seen = '0;
        repeat (SCAN_CYCLES + 8) begin
            @(negedge clk);
            if (!(&disp.an)) begin
                k = lit_digit(disp.an);
                seen[k] = 1'b1;
                check_value("seg_pattern", 32'(hex_font(data[4*k +: 4])), 32'(disp.seg));
            end
        end
        for (int j = 0; j < io_pkg::NUM_DIGITS; j++) begin
            assert (!exp_ctrl.digit_en[j] || seen[j]) else begin
                errors++;
                $display("Enabled digit %0d was never lit during a full scan", j);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Display assertions
    //////////////////////////////////////////////////

    a_single_anode: assert property (@(posedge clk) disable iff (rst)
        $onehot0(~disp.an))
        else begin
            errors++;
            $display("More than one anode driven low at once");
        end

    a_disabled_dark: assert property (@(posedge clk) disable iff (rst)
        (~disp.an & ~exp_ctrl.digit_en) == 4'b0000)
        else begin
            errors++;
            $display("Anode driven low for a disabled digit");
        end

    // Point of the lit digit low exactly when its dp_en is set
    a_point_match: assert property (@(posedge clk) disable iff (rst)
        (&disp.an) || (disp.dp == ~|(~disp.an & exp_ctrl.dp_en)))
        else begin
            errors++;
            $display("Decimal point does not follow dp_en of the lit digit");
        end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] v;
        logic [31:0] rd_data;
        logic        rd_vld;
        logic [15:0] d;
        int          n;

        void'($urandom(39120));
        rst = 1'b1;
        req = '0;
        // In-window address held through reset
        req.addr = io_addr(io_pkg::LED_OFFSET);
        sw  = '0;
        btn = '0;
        repeat (10) @(negedge clk);

        // Reset state sampled before the first clock out of reset
        check_value("reset_valid", 32'd0, 32'(valid));
        rst = 1'b0;
        bus_read(io_addr(io_pkg::SEG_CTRL_OFFSET), rd_data, rd_vld);
        check_value("reset_seg_ctrl", 32'h0000_000F, rd_data);
        bus_read(io_addr(io_pkg::LED_OFFSET), rd_data, rd_vld);
        check_value("reset_led", 32'd0, rd_data);
        bus_read(io_addr(io_pkg::TIMER_OFFSET), rd_data, rd_vld);
        check_near("reset_timer", 32'd0, rd_data);

        // LED writes and readback
        for (int i = 0; i < 8; i++) begin
            v = $urandom;
            bus_write(io_addr(io_pkg::LED_OFFSET), v);
            check_value("led_out", 32'(v[15:0]), 32'(led));
            bus_read(io_addr(io_pkg::LED_OFFSET), rd_data, rd_vld);
            check_value("led_read", {16'h0000, v[15:0]}, rd_data);
        end
        d = v[15:0];
        // Unmapped slot and then the LED offset just outside the window
        bus_write(io_addr(8'h08), 32'hFFFF_FFFF);
        bus_write(32'h0000_8000, ~{16'h0000, d});
        bus_write(32'h0000_7E00, ~{16'h0000, d});
        check_value("led_stray_write", 32'(d), 32'(led));

        // Read valid and latency
        bus_read(io_addr(io_pkg::LED_OFFSET), rd_data, rd_vld);
        check_value("inwin_valid", 32'd1, 32'(rd_vld));
        check_value("inwin_data", 32'(d), rd_data);
        bus_read(32'h1234_7F00, rd_data, rd_vld);
        check_value("outwin_valid", 32'd0, 32'(rd_vld));
        bus_read(io_addr(8'h0C), rd_data, rd_vld);
        check_value("unmapped_valid", 32'd1, 32'(rd_vld));
        check_value("unmapped_data", 32'd0, rd_data);

        // Switches
        for (int i = 0; i < 5; i++) begin
            sw = io_pkg::NUM_SW'($urandom);
            repeat (4) @(negedge clk);
            bus_read(io_addr(io_pkg::SW_OFFSET), rd_data, rd_vld);
            check_value("sw_read", 32'(sw), rd_data);
        end

        // Each button pressed and then released
        for (int b = 0; b < io_pkg::NUM_BTN; b++) begin
            btn = io_pkg::btn_t'(5'(1 << b));
            repeat (io_pkg::DEBOUNCE_CYCLES + 4) @(negedge clk);
            bus_read(io_addr(io_pkg::BTN_OFFSET), rd_data, rd_vld);
            check_value("btn_press", 32'(1 << b), rd_data);
            btn = '0;
            repeat (io_pkg::DEBOUNCE_CYCLES + 4) @(negedge clk);
            bus_read(io_addr(io_pkg::BTN_OFFSET), rd_data, rd_vld);
            check_value("btn_release", 32'd0, rd_data);
        end

        // Short glitch on center must be filtered
        btn.center = 1'b1;
        for (int i = 0; i < 3 * io_pkg::DEBOUNCE_CYCLES; i++) begin
            if (i == io_pkg::DEBOUNCE_CYCLES - 2) btn.center = 1'b0;
            bus_read(io_addr(io_pkg::BTN_OFFSET), rd_data, rd_vld);
            check_value("btn_glitch", 32'd0, rd_data);
        end

        // Seven segment with one fixed pattern and random ones
        for (int i = 0; i < 5; i++) begin
            d = 16'($urandom);
            v = (i == 0) ? 32'h0000_00A5 : $urandom;
            bus_write(io_addr(io_pkg::SEG_OFFSET), 32'(d));
            bus_write(io_addr(io_pkg::SEG_CTRL_OFFSET), v);
            exp_ctrl = io_pkg::seg_ctrl_t'(v[7:0]);
            bus_read(io_addr(io_pkg::SEG_OFFSET), rd_data, rd_vld);
            check_value("seg_data_read", 32'(d), rd_data);
            observe_scan(d);
        end

        // Timer loads including one that wraps
        for (int i = 0; i < 4; i++) begin
            v = (i == 0) ? 32'hFFFF_FFFE : $urandom;
            n = 20 + $urandom_range(0, 80);
            bus_write(io_addr(io_pkg::TIMER_OFFSET), v);
            repeat (n) @(negedge clk);
            bus_read(io_addr(io_pkg::TIMER_OFFSET), rd_data, rd_vld);
            check_near("timer_count", v + 32'(n / io_pkg::TIMER_TICK_CYCLES), rd_data);
        end

        $display("Summary: %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished, %0d errors so far", errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: flist.f
hdl/io_pkg.sv
hdl/io_reg_file.sv
hdl/input_debounce.sv
hdl/seven_seg_scan.sv
hdl/ms_timer.sv
hdl/io_system.sv
bench/tb_io_system.sv

// File: hdl/input_debounce.sv
`timescale 1ns/1ps

module input_debounce (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [io_pkg::NUM_SW-1:0] sw_i,
    input  io_pkg::btn_t              btn_i,
    output logic [io_pkg::NUM_SW-1:0] sw_o,
    output io_pkg::btn_t              btn_o
);

    //////////////////////////////////////////////////
    // Switch synchronizer
    //////////////////////////////////////////////////

    logic [io_pkg::NUM_SW-1:0]  sw_meta;
    logic [io_pkg::NUM_SW-1:0]  sw_sync;
    logic [io_pkg::NUM_BTN-1:0] btn_raw;
    logic [io_pkg::NUM_BTN-1:0] btn_meta;
    logic [io_pkg::NUM_BTN-1:0] btn_sync;
    logic [io_pkg::NUM_BTN-1:0] btn_state;
    logic [io_pkg::DEBOUNCE_CNT_BITS-1:0] stable_cnt [io_pkg::NUM_BTN];

    // Switches are not debounced
    always_ff @(posedge clk) begin
        sw_meta <= sw_i;
        sw_sync <= sw_meta;
    end

    assign sw_o = sw_sync;

    //////////////////////////////////////////////////
    // Button synchronizer and debounce
    //////////////////////////////////////////////////

    // Flatten struct, bit 0 is center
    assign btn_raw = btn_i;

    always_ff @(posedge clk) begin
        btn_meta <= btn_raw;
        btn_sync <= btn_meta;
    end

    // One stability counter per button
    for (genvar b = 0; b < io_pkg::NUM_BTN; b++) begin : g_btn
        always_ff @(posedge clk) begin
            if (rst) begin
                btn_state[b]  <= 1'b0;
                stable_cnt[b] <= '0;
            end else if (btn_sync[b] == btn_state[b]) begin
                // Input agrees with output, restart the count
                stable_cnt[b] <= '0;
            end else if (stable_cnt[b] == io_pkg::DEBOUNCE_CNT_LAST) begin
                // Held long enough, take the new level
                btn_state[b]  <= btn_sync[b];
                stable_cnt[b] <= '0;
            end else begin
                stable_cnt[b] <= stable_cnt[b] + 1'b1;
            end
        end
    end

    assign btn_o = io_pkg::btn_t'(btn_state);

endmodule

// File: hdl/io_pkg.sv
package io_pkg;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    // Base of the 256 byte I/O window
    localparam logic [31:0] IO_START_ADDR = 32'h0000_7F00;
    localparam int IO_ADDR_BITS = 8;

    // Byte offsets inside the window
    localparam logic [7:0] LED_OFFSET      = 8'h00;
    localparam logic [7:0] SW_OFFSET       = 8'h04;
    localparam logic [7:0] SEG_OFFSET      = 8'h18;
    localparam logic [7:0] SEG_CTRL_OFFSET = 8'h1C;
    localparam logic [7:0] BTN_OFFSET      = 8'h24;
    localparam logic [7:0] TIMER_OFFSET    = 8'h30;

    // Word index, taken from offset bits 5:2
    localparam logic [3:0] LED_IDX      = LED_OFFSET[5:2];
    localparam logic [3:0] SW_IDX       = SW_OFFSET[5:2];
    localparam logic [3:0] SEG_IDX      = SEG_OFFSET[5:2];
    localparam logic [3:0] SEG_CTRL_IDX = SEG_CTRL_OFFSET[5:2];
    localparam logic [3:0] BTN_IDX      = BTN_OFFSET[5:2];
    localparam logic [3:0] TIMER_IDX    = TIMER_OFFSET[5:2];

    //////////////////////////////////////////////////
    // Device sizing and tuning
    //////////////////////////////////////////////////

    // All digits lit, no points
    localparam logic [7:0] SEG_CTRL_RESET = 8'h0F;

    localparam int NUM_SW     = 16;
    localparam int NUM_DIGITS = 4;
    localparam int DIGIT_BITS = $clog2(NUM_DIGITS);

    // Shortened tick so simulation stays quick
    localparam int TIMER_TICK_CYCLES   = 16;
    localparam int TIMER_PRESCALE_BITS = $clog2(TIMER_TICK_CYCLES);
    localparam logic [TIMER_PRESCALE_BITS-1:0] TIMER_PRESCALE_LAST =
        TIMER_PRESCALE_BITS'(TIMER_TICK_CYCLES - 1);

    // Samples a button must hold before the output flips
    localparam int DEBOUNCE_CYCLES   = 8;
    localparam int DEBOUNCE_CNT_BITS = $clog2(DEBOUNCE_CYCLES);
    localparam logic [DEBOUNCE_CNT_BITS-1:0] DEBOUNCE_CNT_LAST =
        DEBOUNCE_CNT_BITS'(DEBOUNCE_CYCLES - 1);

    // Low bits divide, top bits pick the digit
    localparam int SCAN_DIV_BITS = 4;
    localparam int SCAN_CNT_BITS = SCAN_DIV_BITS + DIGIT_BITS;

    //////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////

    // Processor side bus, plain strobes
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        wr;
        logic        rd;
    } io_req_t;

    // Center lands in bit 0
    typedef struct packed {
        logic up;
        logic right;
        logic down;
        logic left;
        logic center;
    } btn_t;

    localparam int NUM_BTN = $bits(btn_t);

    typedef struct packed {
        logic [NUM_DIGITS-1:0] dp_en;
        logic [NUM_DIGITS-1:0] digit_en;
    } seg_ctrl_t;

    // All active low, seg is gfedcba
    typedef struct packed {
        logic [NUM_DIGITS-1:0] an;
        logic [6:0]            seg;
        logic                  dp;
    } seg_drive_t;

endpackage

// File: hdl/io_reg_file.sv
`timescale 1ns/1ps

module io_reg_file (
    input  logic                       clk,
    input  logic                       rst,
    input  io_pkg::io_req_t            req_i,
    input  logic [io_pkg::NUM_SW-1:0]  sw_i,
    input  io_pkg::btn_t               btn_i,
    input  logic [31:0]                timer_i,
    output logic [31:0]                rdata_o,
    output logic                       valid_o,
    output logic [15:0]                led_o,
    output logic [15:0]                seg_data_o,
    output io_pkg::seg_ctrl_t          seg_ctrl_o,
    output logic                       timer_load_o,
    output logic [31:0]                timer_wdata_o
);

    //////////////////////////////////////////////////
    // Window and index decode
    //////////////////////////////////////////////////

    logic        in_window;
    logic [3:0]  reg_idx;
    logic        led_we;
    logic        seg_we;
    logic        seg_ctrl_we;
    logic        timer_we;
    logic [15:0] led_q;
    logic [15:0] seg_data_q;
    logic [31:0] rdata_next;

    io_pkg::seg_ctrl_t seg_ctrl_q;

    // Upper 24 bits only
    assign in_window = (req_i.addr[31:io_pkg::IO_ADDR_BITS] ==
                        io_pkg::IO_START_ADDR[31:io_pkg::IO_ADDR_BITS]);

    // 16 word slots, bits above 5 alias
    assign reg_idx = req_i.addr[5:2];

    // Write strobes per register
    always_comb begin
        led_we      = 1'b0;
        seg_we      = 1'b0;
        seg_ctrl_we = 1'b0;
        timer_we    = 1'b0;
        if (in_window && req_i.wr) begin
            case (reg_idx)
                io_pkg::LED_IDX:      led_we      = 1'b1;
                io_pkg::SEG_IDX:      seg_we      = 1'b1;
                io_pkg::SEG_CTRL_IDX: seg_ctrl_we = 1'b1;
                io_pkg::TIMER_IDX:    timer_we    = 1'b1;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Writable registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            led_q      <= '0;
            seg_data_q <= '0;
            seg_ctrl_q <= io_pkg::seg_ctrl_t'(io_pkg::SEG_CTRL_RESET);
        end else begin
            if (led_we) begin
                led_q <= req_i.wdata[15:0];
            end
            if (seg_we) begin
                seg_data_q <= req_i.wdata[15:0];
            end
            // dp_en in 7:4, digit_en in 3:0
            if (seg_ctrl_we) begin
                seg_ctrl_q <= io_pkg::seg_ctrl_t'(req_i.wdata[7:0]);
            end
        end
    end

    assign led_o      = led_q;
    assign seg_data_o = seg_data_q;
    assign seg_ctrl_o = seg_ctrl_q;

    // Timer count itself lives in ms_timer
    assign timer_load_o  = timer_we;
    assign timer_wdata_o = req_i.wdata;

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    // Zero extended words, unmapped slots read 0
    always_comb begin
        case (reg_idx)
            io_pkg::LED_IDX:      rdata_next = {16'h0000, led_q};
            io_pkg::SW_IDX:       rdata_next = {{(32 - io_pkg::NUM_SW){1'b0}}, sw_i};
            io_pkg::SEG_IDX:      rdata_next = {16'h0000, seg_data_q};
            io_pkg::SEG_CTRL_IDX: rdata_next = {24'h000000, seg_ctrl_q};
            io_pkg::BTN_IDX:      rdata_next = {{(32 - io_pkg::NUM_BTN){1'b0}}, btn_i};
            io_pkg::TIMER_IDX:    rdata_next = timer_i;
            default:              rdata_next = '0;
        endcase
    end

    // Data captured every cycle, no rd strobe needed
    always_ff @(posedge clk) begin
        rdata_o <= rdata_next;
    end

    // Valid follows the window hit by one clock
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= in_window;
        end
    end

    // Out of window address never yields valid data
    a_no_valid_outside: assert property (
        @(posedge clk) disable iff (rst)
        !in_window |=> !valid_o
    );

endmodule

// File: hdl/io_system.sv
`timescale 1ns/1ps

module io_system (
    input  logic                      clk,
    input  logic                      rst,
    input  io_pkg::io_req_t           req_i,
    output logic [31:0]               rdata_o,
    output logic                      valid_o,
    input  logic [io_pkg::NUM_SW-1:0] sw_i,
    input  io_pkg::btn_t              btn_i,
    output logic [15:0]               led_o,
    output io_pkg::seg_drive_t        disp_o
);

    //////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////

    // Settled inputs
    logic [io_pkg::NUM_SW-1:0] sw_sync;
    io_pkg::btn_t              btn_deb;

    // Display registers
    logic [15:0]       seg_data;
    io_pkg::seg_ctrl_t seg_ctrl;

    // Timer load and count
    logic        timer_load;
    logic [31:0] timer_wdata;
    logic [31:0] timer_count;

    //////////////////////////////////////////////////
    // Devices
    //////////////////////////////////////////////////

    io_reg_file u_reg_file (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .sw_i          (sw_sync),
        .btn_i         (btn_deb),
        .timer_i       (timer_count),
        .rdata_o       (rdata_o),
        .valid_o       (valid_o),
        .led_o         (led_o),
        .seg_data_o    (seg_data),
        .seg_ctrl_o    (seg_ctrl),
        .timer_load_o  (timer_load),
        .timer_wdata_o (timer_wdata)
    );

    input_debounce u_debounce (
        .clk   (clk),
        .rst   (rst),
        .sw_i  (sw_i),
        .btn_i (btn_i),
        .sw_o  (sw_sync),
        .btn_o (btn_deb)
    );

    seven_seg_scan u_seg_scan (
        .clk    (clk),
        .rst    (rst),
        .data_i (seg_data),
        .ctrl_i (seg_ctrl),
        .disp_o (disp_o)
    );

    ms_timer u_timer (
        .clk          (clk),
        .rst          (rst),
        .load_i       (timer_load),
        .load_value_i (timer_wdata),
        .count_o      (timer_count)
    );

endmodule

// File: hdl/ms_timer.sv
`timescale 1ns/1ps

module ms_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        load_i,
    input  logic [31:0] load_value_i,
    output logic [31:0] count_o
);

    logic [io_pkg::TIMER_PRESCALE_BITS-1:0] presc;

    // Load wins, prescaler restarts so the value holds a full tick
    always_ff @(posedge clk) begin
        if (rst) begin
            presc   <= '0;
            count_o <= '0;
        end else if (load_i) begin
            presc   <= '0;
            count_o <= load_value_i;
        end else if (presc == io_pkg::TIMER_PRESCALE_LAST) begin
            presc   <= '0;
            // Wraps at 32 bits
            count_o <= count_o + 32'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // Prescaler stays within one tick period
    a_presc_range: assert property (
        @(posedge clk) disable iff (rst)
        presc < io_pkg::TIMER_TICK_CYCLES
    );

endmodule

// File: hdl/seven_seg_scan.sv
`timescale 1ns/1ps

module seven_seg_scan (
    input  logic               clk,
    input  logic               rst,
    input  logic [15:0]        data_i,
    input  io_pkg::seg_ctrl_t  ctrl_i,
    output io_pkg::seg_drive_t disp_o
);

    //////////////////////////////////////////////////
    // Refresh counter
    //////////////////////////////////////////////////

    logic [io_pkg::SCAN_CNT_BITS-1:0] scan_cnt;
    logic [io_pkg::DIGIT_BITS-1:0]    digit_sel;
    logic [3:0]                       nibble;
    logic [io_pkg::NUM_DIGITS-1:0]    an_n;
    logic [6:0]                       seg_n;

    // Free running, wraps through all digits
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Top bits step once per 2^SCAN_DIV_BITS clocks
    assign digit_sel = scan_cnt[io_pkg::SCAN_CNT_BITS-1:io_pkg::SCAN_DIV_BITS];

    //////////////////////////////////////////////////
    // Digit select and decode
    //////////////////////////////////////////////////

    // Digit k shows data bits 4k+3 down to 4k
    assign nibble = data_i[{digit_sel, 2'b00} +: 4];

    // Anode low only for the chosen, enabled digit
    always_comb begin
        an_n = '1;
        if (ctrl_i.digit_en[digit_sel]) begin
            an_n[digit_sel] = 1'b0;
        end
    end

    // Hex font, active low gfedcba
    always_comb begin
        case (nibble)
            4'h0:    seg_n = 7'h40;
            4'h1:    seg_n = 7'h79;
            4'h2:    seg_n = 7'h24;
            4'h3:    seg_n = 7'h30;
            4'h4:    seg_n = 7'h19;
            4'h5:    seg_n = 7'h12;
            4'h6:    seg_n = 7'h02;
            4'h7:    seg_n = 7'h78;
            4'h8:    seg_n = 7'h00;
            4'h9:    seg_n = 7'h10;
            4'hA:    seg_n = 7'h08;
            4'hB:    seg_n = 7'h03;
            4'hC:    seg_n = 7'h46;
            4'hD:    seg_n = 7'h21;
            4'hE:    seg_n = 7'h06;
            default: seg_n = 7'h0E;
        endcase
    end

    //////////////////////////////////////////////////
    // Display drive
    //////////////////////////////////////////////////

    assign disp_o.an  = an_n;
    assign disp_o.seg = seg_n;
    // Point follows dp_en of the digit being scanned
    assign disp_o.dp  = ~ctrl_i.dp_en[digit_sel];

    // Never two digits lit together
    a_one_anode: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(~disp_o.an)
    );

endmodule
